// ==== red_pitaya_top.f ====
source/rp_pkg.sv
source/adc_frontend.sv
source/sys_bus_decoder.sv
source/hk_regs.sv
source/signal_router.sv
source/dac_backend.sv
source/red_pitaya_top.sv
tb/tb_red_pitaya_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into a log, judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_red_pitaya_top \
  -f red_pitaya_top.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== tb/tb_red_pitaya_top.sv ====
// testbench for the fast analog path top level
// clock, reset, LFSR pin stimulus, bus read and write tasks
// concurrent assertions on DAC pins, DAC reset, LEDs and bus replies
`timescale 1ns/1ps
`default_nettype none

module tb_red_pitaya_top
  import rp_pkg::*;
();

  localparam logic [31:0] ID_WORD   = 32'h1234_abcd;  // handed to the DUT
  localparam logic [13:0] ZERO_CODE = 14'h1fff;       // offset code of signed zero
  localparam logic [13:0] LVL_ROUTE = 14'h0a3c;
  localparam logic [13:0] LVL_LOOP  = 14'h3123;       // negative level
  localparam int          ACK_LIMIT = 20;             // cycles until a bus timeout
  localparam logic [1:0]  M_PIN_A   = 2'd0;           // expected source per channel
  localparam logic [1:0]  M_PIN_B   = 2'd1;
  localparam logic [1:0]  M_CONST   = 2'd2;

  logic        adc_clk;
  logic        rst_n_i;
  logic [15:0] adc_dat_a_i;
  logic [15:0] adc_dat_b_i;
  sys_req_t    sys_req_i;
  sys_rsp_t    sys_rsp_o;
  dac_pair_t   dac_dat_o;
  logic        dac_rst_o;
  logic [7:0]  led_o;

  logic [31:0] lfsr;
  int          cyc;
  int          mismatch_cnt;
  int          other_err_cnt;
  logic        chk_en;                   // sample path checks active
  logic [1:0]  mode_a;
  logic [1:0]  mode_b;
  logic [13:0] const_a;
  logic [13:0] const_b;
  logic [13:0] pin_a_hist [3];           // pin bits 15:2, 1 to 3 cycles old
  logic [13:0] pin_b_hist [3];
  logic [13:0] exp_ch_a;
  logic [13:0] exp_ch_b;
  logic        rd_chk;
  logic [31:0] rd_exp;
  logic        bus_busy;
  logic [7:0]  led_exp;

  red_pitaya_top #(.HK_ID(ID_WORD)) u_red_pitaya_top (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o),
    .dac_dat_o   (dac_dat_o),
    .dac_rst_o   (dac_rst_o),
    .led_o       (led_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;  // 4 ns period
  end

  // pin history, old pin values seen before the edge's own drive
  always @(posedge adc_clk)
  begin
    cyc           <= cyc + 1;
    pin_a_hist[0] <= adc_dat_a_i[15:2];
    pin_a_hist[1] <= pin_a_hist[0];
    pin_a_hist[2] <= pin_a_hist[1];
    pin_b_hist[0] <= adc_dat_b_i[15:2];
    pin_b_hist[1] <= pin_b_hist[0];
    pin_b_hist[2] <= pin_b_hist[1];
  end

  //////////////////////////////
  // helpers
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois taps 32,22,2,1
  endfunction

  // top bit kept, the other 13 inverted
  function automatic logic [13:0] offset_code(input logic [13:0] s);
    return s ^ 14'h1fff;
  endfunction

  // straight routing: two conversions cancel, pin bits come out as they went in
  function automatic logic [13:0] expected_code(input logic [1:0] mode,
                                                input logic [13:0] pin_a,
                                                input logic [13:0] pin_b,
                                                input logic [13:0] const_code);
    case (mode)
      M_PIN_A: return pin_a;
      M_PIN_B: return pin_b;
      default: return const_code;
    endcase
  endfunction

  function automatic logic [31:0] reg_addr(input logic [2:0] region, input logic [19:0] ofs);
    return {9'h0, region, ofs};
  endfunction

  assign exp_ch_a = expected_code(mode_a, pin_a_hist[2], pin_b_hist[2], const_a);
  assign exp_ch_b = expected_code(mode_b, pin_a_hist[2], pin_b_hist[2], const_b);

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    mismatch_cnt++;
    $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
  endtask

  // 16 LFSR steps, one per pin bit
  task automatic next_pin_word(output logic [15:0] word);
    word = 16'h0;
    repeat (16)
    begin
      word = {word[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic drive_random(input int n);
    logic [15:0] word_a;
    logic [15:0] word_b;
    repeat (n)
    begin
      next_pin_word(word_a);
      next_pin_word(word_b);
      @(posedge adc_clk);
      adc_dat_a_i <= word_a;
      adc_dat_b_i <= word_b;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_req_i <= '{addr: addr, wdata: data, wen: 1'b1, ren: 1'b0};
    bus_busy  <= 1'b1;
    do
    begin
      @(posedge adc_clk);
      sys_req_i.wen <= 1'b0;  // pulse ends, addr and data stay
      waited++;
    end
    while (!sys_rsp_o.ack && waited < ACK_LIMIT);
    if (!sys_rsp_o.ack)
    begin
      other_err_cnt++;
      $display("bus write to %h got no ack within %0d cycles", addr, ACK_LIMIT);
    end
    else if (addr == reg_addr(REGION_HK, HK_LED_OFS))
      led_exp <= data[7:0];
    bus_busy <= 1'b0;
  endtask

  // rdata compared by a_rdata in the ack cycle
  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_val);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_req_i <= '{addr: addr, wdata: 32'h0, wen: 1'b0, ren: 1'b1};
    rd_exp    <= exp_val;
    rd_chk    <= 1'b1;
    bus_busy  <= 1'b1;
    do
    begin
      @(posedge adc_clk);
      sys_req_i.ren <= 1'b0;
      waited++;
    end
    while (!sys_rsp_o.ack && waited < ACK_LIMIT);
    if (!sys_rsp_o.ack)
    begin
      other_err_cnt++;
      $display("bus read from %h got no ack within %0d cycles", addr, ACK_LIMIT);
    end
    rd_chk   <= 1'b0;
    bus_busy <= 1'b0;
  endtask

  // let a new route flush through the pipe, then check again
  task automatic resume_checks();
    repeat (6) @(posedge adc_clk);
    chk_en <= 1'b1;
  endtask

  //////////////////////////////
  // checks
  a_rst_level: assert property (@(posedge adc_clk) cyc >= 2 && !rst_n_i |-> dac_rst_o)
    else report_mismatch("dac_rst_o", 32'd1, 32'($sampled(dac_rst_o)));
  a_rst_dac: assert property (@(posedge adc_clk)
    cyc >= 2 && !rst_n_i |-> dac_dat_o == {ZERO_CODE, ZERO_CODE})
    else report_mismatch("dac_dat_o", 32'({ZERO_CODE, ZERO_CODE}), 32'($sampled(dac_dat_o)));
  a_rst_led: assert property (@(posedge adc_clk) cyc >= 2 && !rst_n_i |-> led_o == 8'h0)
    else report_mismatch("led_o", 32'h0, 32'($sampled(led_o)));
  a_rst_first: assert property (@(posedge adc_clk)
    cyc >= 2 && rst_n_i && !$past(rst_n_i) |-> dac_rst_o)  // one cycle past release
    else report_mismatch("dac_rst_o", 32'd1, 32'($sampled(dac_rst_o)));
  a_rst_release: assert property (@(posedge adc_clk)
    cyc >= 2 && rst_n_i && $past(rst_n_i) |-> !dac_rst_o)
    else report_mismatch("dac_rst_o", 32'd0, 32'($sampled(dac_rst_o)));

  a_ch_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    chk_en |-> dac_dat_o.ch_a == exp_ch_a)
    else report_mismatch("dac_dat_o.ch_a", 32'($sampled(exp_ch_a)),
                         32'($sampled(dac_dat_o.ch_a)));
  a_ch_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    chk_en |-> dac_dat_o.ch_b == exp_ch_b)
    else report_mismatch("dac_dat_o.ch_b", 32'($sampled(exp_ch_b)),
                         32'($sampled(dac_dat_o.ch_b)));

  a_led: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !bus_busy |-> led_o == led_exp)
    else report_mismatch("led_o", 32'($sampled(led_exp)), 32'($sampled(led_o)));
  a_rdata: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    rd_chk && sys_rsp_o.ack |-> sys_rsp_o.rdata == rd_exp)
    else report_mismatch("sys_rsp_o.rdata", $sampled(rd_exp), $sampled(sys_rsp_o.rdata));
  a_err: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    bus_busy && sys_rsp_o.ack |-> !sys_rsp_o.err)
    else report_mismatch("sys_rsp_o.err", 32'd0, 32'($sampled(sys_rsp_o.err)));

  //////////////////////////////
  // stimulus
  initial
  begin
    rst_n_i       = 1'b0;
    adc_dat_a_i   = 16'h7ffc;  // pin code of signed zero
    adc_dat_b_i   = 16'h7ffc;
    sys_req_i     = '0;
    lfsr          = 32'h6c9;
    cyc           = 0;
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    chk_en        = 1'b1;      // covers the hold after release
    mode_a        = M_PIN_A;
    mode_b        = M_PIN_B;
    const_a       = ZERO_CODE;
    const_b       = ZERO_CODE;
    pin_a_hist    = '{default: ZERO_CODE};
    pin_b_hist    = '{default: ZERO_CODE};
    rd_chk        = 1'b0;
    rd_exp        = 32'h0;
    bus_busy      = 1'b0;
    led_exp       = 8'h0;

    repeat (10) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge adc_clk);
    drive_random(200);  // straight path, default routes

    // register readback, sample checks off
    chk_en <= 1'b0;
    read_expect(reg_addr(REGION_HK, HK_ID_OFS), ID_WORD);
    bus_write(reg_addr(REGION_HK, HK_ID_OFS), 32'hffff_ffff);  // ID is read only
    read_expect(reg_addr(REGION_HK, HK_ID_OFS), ID_WORD);
    bus_write(reg_addr(REGION_HK, HK_LED_OFS), 32'h0000_00a5);
    read_expect(reg_addr(REGION_HK, HK_LED_OFS), 32'h0000_00a5);
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h1);
    read_expect(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h1);
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h0);
    read_expect(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h0);
    read_expect(reg_addr(REGION_HK, 20'h100), 32'h0);  // hole reads zero
    bus_write(reg_addr(REGION_ROUTE, RT_LVL_A_OFS), 32'h0000_2b5a);
    read_expect(reg_addr(REGION_ROUTE, RT_LVL_A_OFS), 32'h0000_2b5a);
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ZERO));
    read_expect(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ZERO));
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_B_OFS), 32'(SRC_LEVEL));
    read_expect(reg_addr(REGION_ROUTE, RT_SEL_B_OFS), 32'(SRC_LEVEL));

    // regions 2 to 7 answer at once with zero
    for (int r = 2; r < 8; r++)
      read_expect(reg_addr(3'(r), 20'h44), 32'h0);

    // A from ADC B, B from a level
    bus_write(reg_addr(REGION_ROUTE, RT_LVL_B_OFS), {18'h0, LVL_ROUTE});
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ADC_B));
    mode_a  <= M_PIN_B;
    mode_b  <= M_CONST;
    const_b <= offset_code(LVL_ROUTE);
    resume_checks();
    drive_random(100);
    chk_en <= 1'b0;
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ZERO));
    mode_a  <= M_CONST;
    const_a <= ZERO_CODE;
    resume_checks();
    drive_random(30);

    // digital loop, A settles to the level of B
    chk_en <= 1'b0;
    bus_write(reg_addr(REGION_ROUTE, RT_LVL_B_OFS), {18'h0, LVL_LOOP});
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ADC_B));
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h1);
    const_a <= offset_code(LVL_LOOP);
    const_b <= offset_code(LVL_LOOP);
    resume_checks();
    drive_random(60);

    // back to straight routing
    chk_en <= 1'b0;
    bus_write(reg_addr(REGION_HK, HK_LOOP_OFS), 32'h0);
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_A_OFS), 32'(SRC_ADC_A));
    bus_write(reg_addr(REGION_ROUTE, RT_SEL_B_OFS), 32'(SRC_ADC_B));
    mode_a <= M_PIN_A;
    mode_b <= M_PIN_B;
    resume_checks();
    drive_random(40);
    chk_en <= 1'b0;
    repeat (2) @(posedge adc_clk);

    $display("mismatches: %0d, other errors: %0d", mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/red_pitaya_top.sv ====
// top level, fast analog path and system bus
// ADC front end, bus decoder, housekeeping, router, DAC back end
`timescale 1ns/1ps
`default_nettype none

module red_pitaya_top #(
  parameter logic [31:0] HK_ID = 32'h5250_0001  // board ID word
)(
  input  logic                         adc_clk,
  input  logic                         rst_n_i,
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_a_i,  // ADC CH1
  input  logic [rp_pkg::ADC_PIN_W-1:0] adc_dat_b_i,  // ADC CH2
  input  rp_pkg::sys_req_t             sys_req_i,    // host bus
  output rp_pkg::sys_rsp_t             sys_rsp_o,
  output rp_pkg::dac_pair_t            dac_dat_o,    // both channels
  output logic                         dac_rst_o,
  output logic [7:0]                   led_o
);

  rp_pkg::sample_t  adc_a, adc_b;    // into router
  rp_pkg::sample_t  dac_a, dac_b;    // out of router, also loop source
  rp_pkg::sys_req_t hk_req, rt_req;
  rp_pkg::sys_rsp_t hk_rsp, rt_rsp;
  logic             digital_loop;

  //////////////////////////////
  // input side
  adc_frontend u_adc_frontend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (digital_loop),
    .loop_a_i    (dac_a),
    .loop_b_i    (dac_b),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b)
  );

  //////////////////////////////
  // bus and processing
  sys_bus_decoder u_sys_bus_decoder (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .host_req_i (sys_req_i),
    .host_rsp_o (sys_rsp_o),
    .hk_req_o   (hk_req),
    .hk_rsp_i   (hk_rsp),
    .rt_req_o   (rt_req),
    .rt_rsp_i   (rt_rsp)
  );

  hk_regs #(.HK_ID(HK_ID)) u_hk_regs (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (hk_req),
    .rsp_o     (hk_rsp),
    .loop_en_o (digital_loop),
    .led_o     (led_o)
  );

  signal_router u_signal_router (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (rt_req),
    .rsp_o   (rt_rsp),
    .adc_a_i (adc_a),
    .adc_b_i (adc_b),
    .dac_a_o (dac_a),
    .dac_b_o (dac_b)
  );

  //////////////////////////////
  // output side
  dac_backend u_dac_backend (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .dac_a_i   (dac_a),
    .dac_b_i   (dac_b),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// ==== source/dac_backend.sv ====
// DAC output register, two's complement to offset code
// registered DAC reset level
`timescale 1ns/1ps
`default_nettype none

module dac_backend
  import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  sample_t   dac_a_i,
  input  sample_t   dac_b_i,
  output dac_pair_t dac_dat_o,
  output logic      dac_rst_o   // active high
);

  dac_pair_t dac_q;
  logic      dac_rst_q;

  //////////////////////////////
  // output register
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_q.ch_a <= ofs_conv({SAMPLE_W{1'b0}});  // mid scale
      dac_q.ch_b <= ofs_conv({SAMPLE_W{1'b0}});
      dac_rst_q  <= 1'b1;
    end
    else
    begin
      dac_q.ch_a <= ofs_conv(dac_a_i);
      dac_q.ch_b <= ofs_conv(dac_b_i);
      dac_rst_q  <= 1'b0;  // drops one edge after release
    end
  end

  assign dac_dat_o = dac_q;
  assign dac_rst_o = dac_rst_q;

  // no data moves on the pins while the DAC is still held in reset
  a_rst_quiet: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    dac_rst_o |=> $stable(dac_dat_o));

endmodule

`default_nettype wire

// ==== source/signal_router.sv ====
// signal router, region 1
// per-channel source select and constant level registers
// registered DAC sample per channel
`timescale 1ns/1ps
`default_nettype none

module signal_router
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  sys_req_t req_i,
  output sys_rsp_t rsp_o,
  input  sample_t  adc_a_i,
  input  sample_t  adc_b_i,
  output sample_t  dac_a_o,
  output sample_t  dac_b_o
);

  route_sel_t  sel_a_q, sel_b_q;
  sample_t     lvl_a_q, lvl_b_q;
  sample_t     dac_a_q, dac_b_q;
  logic        ack_q;
  logic [31:0] rdata_q;

  // one source mux, used for both channels
  function automatic sample_t route(input route_sel_t sel, input sample_t a,
                                    input sample_t b, input sample_t lvl);
    case (sel)
      SRC_ADC_A: return a;
      SRC_ADC_B: return b;
      SRC_LEVEL: return lvl;
      default:   return '0;  // SRC_ZERO
    endcase
  endfunction

  //////////////////////////////
  // config registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sel_a_q <= SRC_ADC_A;  // straight through after reset
      sel_b_q <= SRC_ADC_B;
      lvl_a_q <= '0;
      lvl_b_q <= '0;
      ack_q   <= 1'b0;
    end
    else
    begin
      ack_q <= req_i.wen | req_i.ren;
      if (req_i.wen)
      begin
        case (req_i.addr[19:0])
          RT_SEL_A_OFS: sel_a_q <= route_sel_t'(req_i.wdata[1:0]);
          RT_SEL_B_OFS: sel_b_q <= route_sel_t'(req_i.wdata[1:0]);
          RT_LVL_A_OFS: lvl_a_q <= sample_t'(req_i.wdata[SAMPLE_W-1:0]);
          RT_LVL_B_OFS: lvl_b_q <= sample_t'(req_i.wdata[SAMPLE_W-1:0]);
          default:      ;
        endcase
      end
    end
  end

  // readback, raw fields zero extended
  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
    begin
      case (req_i.addr[19:0])
        RT_SEL_A_OFS: rdata_q <= {30'h0, sel_a_q};
        RT_SEL_B_OFS: rdata_q <= {30'h0, sel_b_q};
        RT_LVL_A_OFS: rdata_q <= {{(32-SAMPLE_W){1'b0}}, lvl_a_q};
        RT_LVL_B_OFS: rdata_q <= {{(32-SAMPLE_W){1'b0}}, lvl_b_q};
        default:      rdata_q <= 32'h0;
      endcase
    end
  end

  //////////////////////////////
  // sample path
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_a_q <= '0;  // DAC sits at mid scale
      dac_b_q <= '0;
    end
    else
    begin
      dac_a_q <= route(sel_a_q, adc_a_i, adc_b_i, lvl_a_q);
      dac_b_q <= route(sel_b_q, adc_a_i, adc_b_i, lvl_b_q);
    end
  end

  assign dac_a_o = dac_a_q;
  assign dac_b_o = dac_b_q;
  assign rsp_o   = '{rdata: rdata_q, err: 1'b0, ack: ack_q};

  a_zero_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sel_a_q == SRC_ZERO |=> dac_a_o == '0);
  a_zero_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    sel_b_q == SRC_ZERO |=> dac_b_o == '0);

endmodule

`default_nettype wire

// ==== source/hk_regs.sv ====
// housekeeping registers, region 0
// read-only ID, digital loop enable, LED register
`timescale 1ns/1ps
`default_nettype none

module hk_regs
  import rp_pkg::*;
#(
  parameter logic [31:0] HK_ID = 32'h0
)(
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  sys_req_t   req_i,
  output sys_rsp_t   rsp_o,
  output logic       loop_en_o,  // ADC <- DAC loopback
  output logic [7:0] led_o
);

  logic        loop_q;
  logic [7:0]  led_q;
  logic        ack_q;
  logic [31:0] rdata_q;

  //////////////////////////////
  // write side
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= 8'h0;
    end
    else if (req_i.wen)
    begin
      case (req_i.addr[19:0])
        HK_LOOP_OFS: loop_q <= req_i.wdata[0];
        HK_LED_OFS:  led_q  <= req_i.wdata[7:0];
        default:     ;  // ID and holes ignore writes
      endcase
    end
  end

  //////////////////////////////
  // read side, answers one cycle after the enable
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.wen | req_i.ren;  // writes acked too
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
    begin
      case (req_i.addr[19:0])
        HK_ID_OFS:   rdata_q <= HK_ID;
        HK_LOOP_OFS: rdata_q <= {31'h0, loop_q};
        HK_LED_OFS:  rdata_q <= {24'h0, led_q};
        default:     rdata_q <= 32'h0;  // unmapped reads zero
      endcase
    end
  end

  assign rsp_o     = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
  assign loop_en_o = loop_q;
  assign led_o     = led_q;

  // one ack per enable, high for a single cycle
  a_ack_timing: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (req_i.wen || req_i.ren) |=> rsp_o.ack ##1 !rsp_o.ack);

endmodule

`default_nettype wire

// ==== source/sys_bus_decoder.sv ====
// system bus decoder, eight regions on addr[22:20]
// enable fan-out, response mux, idle replies for regions 2 to 7
`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  sys_req_t host_req_i,
  output sys_rsp_t host_rsp_o,
  output sys_req_t hk_req_o,   // region 0
  input  sys_rsp_t hk_rsp_i,
  output sys_req_t rt_req_o,   // region 1
  input  sys_rsp_t rt_rsp_i
);

  logic [2:0]           region;
  logic [N_REGIONS-1:0] cs;      // one-hot chip select

  assign region = host_req_i.addr[22:20];
  assign cs     = N_REGIONS'(1) << region;

  //////////////////////////////
  // request fan-out
  always_comb
  begin
    hk_req_o     = host_req_i;                        // addr, wdata shared
    hk_req_o.wen = host_req_i.wen & cs[REGION_HK];
    hk_req_o.ren = host_req_i.ren & cs[REGION_HK];
    rt_req_o     = host_req_i;
    rt_req_o.wen = host_req_i.wen & cs[REGION_ROUTE];
    rt_req_o.ren = host_req_i.ren & cs[REGION_ROUTE];
  end

  //////////////////////////////
  // response mux
  always_comb
  begin
    case (region)
      REGION_HK:    host_rsp_o = hk_rsp_i;
      REGION_ROUTE: host_rsp_o = rt_rsp_i;
      default:
      begin
        // nothing mapped, answer at once
        host_rsp_o.rdata = 32'h0;
        host_rsp_o.err   = 1'b0;
        host_rsp_o.ack   = 1'b1;
      end
    endcase
  end

  // host never issues a read and a write in the same cycle
  a_no_wen_ren: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    !(host_req_i.wen && host_req_i.ren));

endmodule

`default_nettype wire

// ==== source/adc_frontend.sv ====
// ADC input registers for both channels
// offset code to two's complement, digital loopback select
`timescale 1ns/1ps
`default_nettype none

module adc_frontend
  import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,  // ADC CH1 pins
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,  // ADC CH2 pins
  input  logic                 loop_en_i,    // from housekeeping
  input  sample_t              loop_a_i,     // router outputs
  input  sample_t              loop_b_i,
  output sample_t              adc_a_o,
  output sample_t              adc_b_o
);

  logic [SAMPLE_W-1:0] adc_dat_a_q;  // raw pin code
  logic [SAMPLE_W-1:0] adc_dat_b_q;

  //////////////////////////////
  // pin registers
  // bits 1:0 reserved for a 16 bit part, dropped here
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      // pin code that reads back as signed zero
      adc_dat_a_q <= ofs_conv({SAMPLE_W{1'b0}});
      adc_dat_b_q <= ofs_conv({SAMPLE_W{1'b0}});
    end
    else
    begin
      adc_dat_a_q <= adc_dat_a_i[ADC_PIN_W-1:ADC_PIN_W-SAMPLE_W];
      adc_dat_b_q <= adc_dat_b_i[ADC_PIN_W-1:ADC_PIN_W-SAMPLE_W];
    end
  end

  //////////////////////////////
  // conversion and loopback
  // loop path closes through the router register only
  assign adc_a_o = loop_en_i ? loop_a_i : sample_t'(ofs_conv(adc_dat_a_q));
  assign adc_b_o = loop_en_i ? loop_b_i : sample_t'(ofs_conv(adc_dat_b_q));

endmodule

`default_nettype wire

// ==== source/rp_pkg.sv ====
// shared widths, sample and DAC types
// system bus request and response structs
// region numbers, route selects and register offsets
`default_nettype none

package rp_pkg;

  localparam int SAMPLE_W  = 14;  // ADC and DAC sample width
  localparam int ADC_PIN_W = 16;  // pin word, two lowest bits reserved

  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // both DAC channels leave together, offset coded
  typedef struct packed {
    logic [SAMPLE_W-1:0] ch_a;
    logic [SAMPLE_W-1:0] ch_b;
  } dac_pair_t;

  //////////////////////////////
  // system bus
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;    // one cycle pulse
    logic        ren;    // one cycle pulse
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        ack;
  } sys_rsp_t;

  localparam int         N_REGIONS    = 8;     // addr[22:20]
  localparam logic [2:0] REGION_HK    = 3'd0;
  localparam logic [2:0] REGION_ROUTE = 3'd1;

  typedef enum logic [1:0] {SRC_ADC_A, SRC_ADC_B, SRC_LEVEL, SRC_ZERO} route_sel_t;

  // offsets inside a region, addr[19:0]
  localparam logic [19:0] HK_ID_OFS    = 20'h00;
  localparam logic [19:0] HK_LOOP_OFS  = 20'h04;
  localparam logic [19:0] HK_LED_OFS   = 20'h30;
  localparam logic [19:0] RT_SEL_A_OFS = 20'h00;
  localparam logic [19:0] RT_SEL_B_OFS = 20'h04;
  localparam logic [19:0] RT_LVL_A_OFS = 20'h08;
  localparam logic [19:0] RT_LVL_B_OFS = 20'h0C;

  // negative slope offset code <-> two's complement, same rule both ways
  function automatic logic [SAMPLE_W-1:0] ofs_conv(input logic [SAMPLE_W-1:0] code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

endpackage

`default_nettype wire
